// File: hw/rv_isa_pkg.sv
// rv32i opcode, funct3/funct7, alu operation and memory width encodings
package rv_isa_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // alu ops, branch compares return 1 or 0
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_PASS_B
  } alu_op_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_width_e;

  // funct3 for op / op-imm
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7, alt selects sub / sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // fixed encodings
  localparam logic [31:0] NOP_INSTR    = 32'h00000013;
  localparam logic [31:0] EBREAK_INSTR = 32'h00100073;

endpackage

// File: hw/core_pkg.sv
// data width, word type and the fetch, control and retire bundles of the pipeline
package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // fetch to second stage
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } fetch_t;

  // decoded controls of one instruction
  typedef struct packed {
    rv_isa_pkg::alu_op_e    alu_op;
    // operand b from immediate
    logic                   use_imm;
    // operand a from pc
    logic                   use_pc;
    logic                   reg_we;
    logic                   mem_we;
    logic                   mem_re;
    rv_isa_pkg::mem_width_e mem_width;
    logic                   load_unsigned;
    logic                   is_branch;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_ebreak;
    logic                   illegal;
  } ctrl_t;

  // one retired instruction as seen on the port
  typedef struct packed {
    logic       valid;
    word_t      pc;
    logic [4:0] rd;
    logic       reg_we;
    word_t      wdata;
  } retire_t;

endpackage

// File: hw/fetch_unit.sv
// program counter, instruction memory with load port, next-pc selection
`timescale 1ns/100ps

module fetch_unit #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          advance,
  input  logic                          redirect,
  input  core_pkg::word_t               redirect_pc,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
  input  core_pkg::word_t               imem_wdata,
  output core_pkg::fetch_t              fetch
);
  import core_pkg::*;
  import rv_isa_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  word_t       pc;
  word_t       imem [IMEM_WORDS];
  logic [29:0] word_idx;
  logic        in_range;

  // program load port, word granular
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // pc steps by 4 unless the second stage redirects
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (advance) begin
      pc <= redirect ? redirect_pc : pc + 32'd4;
    end
  end

  assign word_idx = pc[XLEN-1:2];
  assign in_range = word_idx < IMEM_WORDS;

  // combinational read
  // past the end reads a bubble
  always_comb begin
    fetch.pc = pc;
    if (in_range) begin
      fetch.valid = 1'b1;
      fetch.instr = imem[word_idx[AW-1:0]];
    end else begin
      fetch.valid = 1'b0;
      fetch.instr = NOP_INSTR;
    end
  end

endmodule

// File: hw/stage_reg.sv
// generic pipeline register with enable, flush and reset to a bubble
`timescale 1ns/100ps

module stage_reg #(
  parameter type      payload_t = logic,
  parameter payload_t BUBBLE    = '0
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     enable,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // flush wins over enable
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= BUBBLE;
    end else if (enable) begin
      q <= d;
    end
  end

endmodule

// File: hw/decoder.sv
// rv32i decode to register indices, immediate and control bundle with illegal detection
`timescale 1ns/100ps

module decoder (
  input  core_pkg::word_t instr,
  output logic [4:0]      rd,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output core_pkg::word_t imm,
  output core_pkg::ctrl_t ctrl
);
  import rv_isa_pkg::*;

  // shared by op and op-imm
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_ADD;
    endcase
    return op;
  endfunction

  logic [2:0] f3;
  logic [6:0] f7;
  logic       bad;

  assign rd  = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign f3  = instr[14:12];
  assign f7  = instr[31:25];

  always_comb begin
    bad  = 1'b0;
    imm  = {{20{instr[31]}}, instr[31:20]};
    ctrl = '0;
    ctrl.alu_op = ALU_ADD;
    // loads and stores share funct3 layout
    ctrl.mem_width = mem_width_e'(f3[1:0]);
    ctrl.load_unsigned = f3[2];
    case (instr[6:0])
      OPC_LUI: begin
        imm = {instr[31:12], 12'b0};
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
      end
      OPC_AUIPC: begin
        imm = {instr[31:12], 12'b0};
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
      end
      OPC_JAL: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.is_jal  = 1'b1;
      end
      OPC_JALR: begin
        bad = f3 != 3'b000;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.is_jalr = 1'b1;
      end
      OPC_BRANCH: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        ctrl.is_branch = 1'b1;
        case (f3)
          F3_BEQ:  ctrl.alu_op = ALU_BEQ;
          F3_BNE:  ctrl.alu_op = ALU_BNE;
          F3_BLT:  ctrl.alu_op = ALU_BLT;
          F3_BGE:  ctrl.alu_op = ALU_BGE;
          F3_BLTU: ctrl.alu_op = ALU_BLTU;
          F3_BGEU: ctrl.alu_op = ALU_BGEU;
          default: bad = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // lb lh lw lbu lhu only
        bad = (f3[1:0] == 2'b11) || (f3 == 3'b110);
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.mem_re  = 1'b1;
      end
      OPC_STORE: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        bad = f3[2] || (f3[1:0] == 2'b11);
        ctrl.use_imm = 1'b1;
        ctrl.mem_we  = 1'b1;
      end
      OPC_OP_IMM: begin
        // shifts keep funct7 in the immediate field
        if (f3 == F3_SLL) begin
          bad = f7 != F7_BASE;
        end else if (f3 == F3_SRL_SRA) begin
          bad = (f7 != F7_BASE) && (f7 != F7_ALT);
        end
        ctrl.alu_op  = arith_op(f3, (f3 == F3_SRL_SRA) && instr[30]);
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
      end
      OPC_OP: begin
        // alt funct7 only for sub and sra
        if (f7 == F7_ALT) begin
          bad = (f3 != F3_ADD_SUB) && (f3 != F3_SRL_SRA);
        end else begin
          bad = f7 != F7_BASE;
        end
        ctrl.alu_op = arith_op(f3, f7 == F7_ALT);
        ctrl.reg_we = 1'b1;
      end
      OPC_SYSTEM: begin
        // ecall and csr ops are not supported
        bad = instr != EBREAK_INSTR;
        ctrl.is_ebreak = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      ctrl = '0;
      ctrl.illegal = 1'b1;
    end
  end

endmodule

// File: hw/reg_file.sv
// 32 x 32 register file, two combinational reads, one synchronous write, x0 reads zero
`timescale 1ns/100ps

module reg_file (
  input  logic            clk,
  input  logic            we,
  input  logic [4:0]      waddr,
  input  logic [4:0]      raddr_a,
  input  logic [4:0]      raddr_b,
  input  core_pkg::word_t wdata,
  output core_pkg::word_t rdata_a,
  output core_pkg::word_t rdata_b
);
  import core_pkg::*;

  word_t regs [32];

  // x0 never written
  always_ff @(posedge clk) begin
    if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 forced to zero on read
  assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

// File: hw/alu.sv
// arithmetic, logic, shift, compare and branch-condition results
`timescale 1ns/100ps

module alu (
  input  core_pkg::word_t     a,
  input  core_pkg::word_t     b,
  input  rv_isa_pkg::alu_op_e op,
  output core_pkg::word_t     result
);
  import rv_isa_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = a == b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'b0, lt_s};
      ALU_SLTU:   result = {31'b0, lt_u};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      // branch conditions
      ALU_BEQ:    result = {31'b0, eq};
      ALU_BNE:    result = {31'b0, !eq};
      ALU_BLT:    result = {31'b0, lt_s};
      ALU_BGE:    result = {31'b0, !lt_s};
      ALU_BLTU:   result = {31'b0, lt_u};
      ALU_BGEU:   result = {31'b0, !lt_u};
      // lui
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

// File: hw/data_mem.sv
// little-endian byte data ram with width-masked stores and sign or zero extended loads
`timescale 1ns/100ps

module data_mem #(
  parameter int DMEM_BYTES = 1024
) (
  input  logic                   clk,
  input  logic                   we,
  input  core_pkg::word_t        addr,
  input  rv_isa_pkg::mem_width_e width,
  input  logic                   load_unsigned,
  input  core_pkg::word_t        wdata,
  output core_pkg::word_t        rdata
);
  import rv_isa_pkg::*;

  localparam int AW = $clog2(DMEM_BYTES);

  logic [7:0]    mem [DMEM_BYTES];
  logic [AW-1:0] a0;
  logic [AW-1:0] a1;
  logic [AW-1:0] a2;
  logic [AW-1:0] a3;
  logic [7:0]    b0;
  logic [7:0]    b1;
  logic [15:0]   half;

  // byte lanes, addresses wrap inside the ram
  assign a0 = addr[AW-1:0];
  assign a1 = a0 + AW'(1);
  assign a2 = a0 + AW'(2);
  assign a3 = a0 + AW'(3);

  always_ff @(posedge clk) begin
    if (we) begin
      mem[a0] <= wdata[7:0];
      if (width != MEM_BYTE) begin
        mem[a1] <= wdata[15:8];
      end
      if (width == MEM_WORD) begin
        mem[a2] <= wdata[23:16];
        mem[a3] <= wdata[31:24];
      end
    end
  end

  assign b0   = mem[a0];
  assign b1   = mem[a1];
  assign half = {b1, b0};

  // extension by width, top bit replicated unless unsigned
  always_comb begin
    case (width)
      MEM_BYTE: rdata = {{24{b0[7] & !load_unsigned}}, b0};
      MEM_HALF: rdata = {{16{half[15] & !load_unsigned}}, half};
      default:  rdata = {mem[a3], mem[a2], half};
    endcase
  end

endmodule

// File: hw/rv_core.sv
// two-stage rv32i core top with operand, writeback and redirect selection plus halt flags
`timescale 1ns/100ps

module rv_core #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_BYTES = 1024
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
  input  core_pkg::word_t               imem_wdata,
  output core_pkg::retire_t             retire,
  output logic                          halted,
  output logic                          illegal
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam fetch_t  FETCH_BUBBLE  = '{valid: 1'b0, pc: '0, instr: NOP_INSTR};
  localparam retire_t RETIRE_BUBBLE = '0;

  logic       advance;
  logic       exec;
  logic       taken;
  logic       redirect;
  word_t      redirect_pc;
  fetch_t     fetch;
  fetch_t     id;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  word_t      imm;
  ctrl_t      ctrl;
  word_t      rdata_a;
  word_t      rdata_b;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_result;
  word_t      load_data;
  word_t      wb_data;
  retire_t    ret_d;

  // halted freezes pc and if_id, run low stalls
  assign advance = run && !halted;
  // bubbles have no side effects
  assign exec    = advance && id.valid;

  fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
    .clk        (clk),
    .reset      (reset),
    .advance    (advance),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .imem_we    (imem_we && !run),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .fetch      (fetch)
  );

  // fetch/decode register, a redirect drops the wrong-path fetch
  stage_reg #(.payload_t(fetch_t), .BUBBLE(FETCH_BUBBLE)) if_id (
    .clk   (clk),
    .reset (reset),
    .enable(advance),
    .flush (advance && redirect),
    .d     (fetch),
    .q     (id)
  );

  decoder u_decoder (
    .instr(id.instr),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (rs2),
    .imm  (imm),
    .ctrl (ctrl)
  );

  reg_file u_regs (
    .clk    (clk),
    .we     (exec && ctrl.reg_we),
    .waddr  (rd),
    .raddr_a(rs1),
    .raddr_b(rs2),
    .wdata  (wb_data),
    .rdata_a(rdata_a),
    .rdata_b(rdata_b)
  );

  // auipc and jal take the pc, immediates except for branches
  assign op_a = ctrl.use_pc ? id.pc : rdata_a;
  assign op_b = ctrl.use_imm ? imm : rdata_b;

  alu u_alu (
    .a     (op_a),
    .b     (op_b),
    .op    (ctrl.alu_op),
    .result(alu_result)
  );

  // address from alu, store data straight from rs2
  data_mem #(.DMEM_BYTES(DMEM_BYTES)) u_dmem (
    .clk          (clk),
    .we           (exec && ctrl.mem_we),
    .addr         (alu_result),
    .width        (ctrl.mem_width),
    .load_unsigned(ctrl.load_unsigned),
    .wdata        (rdata_b),
    .rdata        (load_data)
  );

  // branch condition comes back as bit 0
  assign taken       = ctrl.is_branch && alu_result[0];
  assign redirect    = id.valid && (ctrl.is_jal || ctrl.is_jalr || taken);
  assign redirect_pc = ctrl.is_jalr ? {alu_result[XLEN-1:1], 1'b0} : id.pc + imm;

  always_comb begin
    if (ctrl.is_jal || ctrl.is_jalr) begin
      wb_data = id.pc + 32'd4;
    end else if (ctrl.mem_re) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

  // illegal instructions never retire
  assign ret_d = '{
    valid:  exec && !ctrl.illegal,
    pc:     id.pc,
    rd:     rd,
    reg_we: ctrl.reg_we,
    wdata:  wb_data
  };

  // sampled every clock so a stall shows valid low
  stage_reg #(.payload_t(retire_t), .BUBBLE(RETIRE_BUBBLE)) ret (
    .clk   (clk),
    .reset (reset),
    .enable(1'b1),
    .flush (1'b0),
    .d     (ret_d),
    .q     (retire)
  );

  // sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (exec) begin
      if (ctrl.illegal) begin
        illegal <= 1'b1;
        halted  <= 1'b1;
      end else if (ctrl.is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

// File: sim/tb_rv_core.sv
// testbench for rv_core: instruction encoders, program builder, compare tasks, directed tests
`timescale 1ns/100ps

module tb_rv_core;
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam int IMEM_WORDS         = 256;
  localparam int DMEM_BYTES         = 1024;
  localparam int AW                 = $clog2(IMEM_WORDS);
  localparam int NUM_PROGRAMS       = 12;
  localparam int CYCLES_PER_PROGRAM = 64;
  localparam int TIMEOUT_CYCLES     = NUM_PROGRAMS * CYCLES_PER_PROGRAM;

  logic          clk;
  logic          reset;
  logic          run;
  logic          imem_we;
  logic [AW-1:0] imem_addr;
  word_t         imem_wdata;
  retire_t       retire;
  logic          halted;
  logic          illegal;

  // program being built and the retire stream it should give
  word_t   prog[$];
  retire_t exp_q[$];

  integer seed;
  int     retire_errors = 0;
  int     flag_errors   = 0;
  int     seq_errors    = 0;
  int     cycle_count   = 0;

  rv_core #(
    .IMEM_WORDS(IMEM_WORDS),
    .DMEM_BYTES(DMEM_BYTES)
  ) DUT (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_wdata(imem_wdata),
    .retire    (retire),
    .halted    (halted),
    .illegal   (illegal)
  );

  always #10 clk = ~clk;

  // watchdog over the whole run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // rv32i instruction formats
  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  // offset bit 0 is implied
  function automatic word_t b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_type(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t next_pc();
    return word_t'(prog.size() * 4);
  endfunction

  function automatic void new_program();
    prog.delete();
    exp_q.delete();
  endfunction

  // instruction that must show up on the retire port
  function automatic void expect_retire(word_t instr, logic [4:0] rd, logic we, word_t wdata);
    retire_t e;
    e = '{valid: 1'b1, pc: next_pc(), rd: rd, reg_we: we, wdata: wdata};
    exp_q.push_back(e);
    prog.push_back(instr);
  endfunction

  // jumped over or never reached
  function automatic void skip_over(word_t instr);
    prog.push_back(instr);
  endfunction

  // lui + addi, upper part rounded for the signed low 12 bits
  function automatic void build_const(logic [4:0] rd, word_t val);
    word_t upper;
    upper = (val + 32'h800) & 32'hfffff000;
    expect_retire(u_type(upper[31:12], rd, OPC_LUI), rd, 1'b1, upper);
    expect_retire(i_type(val[11:0], rd, F3_ADD_SUB, rd, OPC_OP_IMM), rd, 1'b1, val);
  endfunction

  task automatic check_retire(input retire_t got, input retire_t want, input string what);
    logic  bad;
    string got_s;
    string want_s;
    bad = (got.valid !== want.valid) || (got.pc !== want.pc) || (got.reg_we !== want.reg_we);
    // rd and wdata only mean something when a register is written
    if (want.reg_we) begin
      bad = bad || (got.rd !== want.rd) || (got.wdata !== want.wdata);
    end
    if (bad) begin
      retire_errors++;
      got_s  = $sformatf("pc %h rd x%0d we %b data %h", got.pc, got.rd, got.reg_we, got.wdata);
      want_s = $sformatf("pc %h rd x%0d we %b data %h", want.pc, want.rd, want.reg_we,
                         want.wdata);
      $display("[ERROR] %0t: %s retire was %s, expected %s", $time, what, got_s, want_s);
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      flag_errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // imem writes only land while run is low
  task automatic load_program();
    @(negedge clk);
    run = 1'b0;
    foreach (prog[i]) begin
      imem_we    = 1'b1;
      imem_addr  = AW'(i);
      imem_wdata = prog[i];
      @(negedge clk);
    end
    imem_we = 1'b0;
  endtask

  task automatic reset_core();
    reset = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_flag(halted, 1'b0, "halted after reset");
    check_flag(illegal, 1'b0, "illegal after reset");
    check_flag(retire.valid, 1'b0, "retire.valid after reset");
  endtask

  // load, reset, run until halted, compare valid retire entries in order
  task automatic run_program(input string name, input logic ebreak_end, input logic want_ill);
    int idx;
    int cycles;
    idx    = 0;
    cycles = 0;
    load_program();
    reset_core();
    run = 1'b1;
    while (!halted && (cycles < CYCLES_PER_PROGRAM)) begin
      @(negedge clk);
      cycles++;
      if (retire.valid) begin
        if (idx < exp_q.size()) begin
          check_retire(retire, exp_q[idx], name);
          idx++;
          // ebreak raises halted together with its own entry
          check_flag(halted, ebreak_end && (idx == exp_q.size()), {name, " halted"});
        end else begin
          seq_errors++;
          $display("%s: unexpected retire at pc %h after the expected stream", name, retire.pc);
        end
      end
    end
    if (!halted) begin
      seq_errors++;
      $display("%s: program did not halt within %0d cycles", name, CYCLES_PER_PROGRAM);
    end
    if (idx != exp_q.size()) begin
      seq_errors++;
      $display("%s: only %0d of %0d expected instructions retired", name, idx, exp_q.size());
    end
    check_flag(illegal, want_ill, {name, " illegal"});
  endtask

  task automatic stays_halted(input int n, input string what);
    repeat (n) begin
      @(negedge clk);
      check_flag(retire.valid, 1'b0, {what, " retire.valid"});
      check_flag(halted, 1'b1, {what, " halted"});
      check_flag(illegal, 1'b0, {what, " illegal"});
    end
  endtask

  task automatic arithmetic_ops();
    word_t       a;
    word_t       b;
    logic [11:0] i12;
    a   = $random(seed);
    b   = $random(seed);
    i12 = 12'($random(seed));
    new_program();
    build_const(5'd1, a);
    build_const(5'd2, b);
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd3), 5'd3, 1'b1, a + b);
    expect_retire(r_type(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd4), 5'd4, 1'b1, a - b);
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd5), 5'd5, 1'b1, a ^ b);
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd6), 5'd6, 1'b1, a | b);
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd7), 5'd7, 1'b1, a & b);
    // register shifts use rs2[4:0]
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_SLL, 5'd8), 5'd8, 1'b1, a << b[4:0]);
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_SRL_SRA, 5'd9), 5'd9, 1'b1, a >> b[4:0]);
    expect_retire(r_type(F7_ALT, 5'd2, 5'd1, F3_SRL_SRA, 5'd10), 5'd10, 1'b1,
                  word_t'($signed(a) >>> b[4:0]));
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd11), 5'd11, 1'b1,
                  {31'b0, $signed(a) < $signed(b)});
    expect_retire(r_type(F7_BASE, 5'd2, 5'd1, F3_SLTU, 5'd12), 5'd12, 1'b1, {31'b0, a < b});
    // immediate forms
    expect_retire(i_type(i12, 5'd1, F3_ADD_SUB, 5'd13, OPC_OP_IMM), 5'd13, 1'b1,
                  a + sext12(i12));
    expect_retire(i_type(12'hfff, 5'd1, F3_XOR, 5'd14, OPC_OP_IMM), 5'd14, 1'b1, ~a);
    expect_retire(i_type({F7_ALT, 5'd7}, 5'd1, F3_SRL_SRA, 5'd15, OPC_OP_IMM), 5'd15, 1'b1,
                  word_t'($signed(a) >>> 7));
    expect_retire(i_type({F7_BASE, 5'd3}, 5'd2, F3_SLL, 5'd16, OPC_OP_IMM), 5'd16, 1'b1,
                  b << 3);
    expect_retire(i_type(i12, 5'd1, F3_SLT, 5'd17, OPC_OP_IMM), 5'd17, 1'b1,
                  {31'b0, $signed(a) < $signed(sext12(i12))});
    expect_retire(i_type(i12, 5'd2, F3_SLTU, 5'd18, OPC_OP_IMM), 5'd18, 1'b1,
                  {31'b0, b < sext12(i12)});
    // x0 write retires its value but x0 still reads zero
    expect_retire(i_type(12'd5, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP_IMM), 5'd0, 1'b1, a + 32'd5);
    expect_retire(r_type(F7_BASE, 5'd0, 5'd0, F3_ADD_SUB, 5'd19), 5'd19, 1'b1, 32'd0);
    expect_retire(r_type(F7_BASE, 5'd1, 5'd0, F3_OR, 5'd20), 5'd20, 1'b1, a);
    expect_retire(EBREAK_INSTR, 5'd0, 1'b0, 32'd0);
    run_program("arithmetic", 1'b1, 1'b0);
  endtask

  task automatic load_store_widths();
    word_t w;
    word_t v;
    // sign bits of byte 1 and half 1 set so extension shows
    w = word_t'($random(seed)) | 32'h8000_8000;
    v = $random(seed);
    new_program();
    build_const(5'd1, w);
    expect_retire(i_type(12'h100, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM), 5'd2, 1'b1, 32'h100);
    // sw then every load width from the same word
    expect_retire(s_type(12'd0, 5'd1, 5'd2, 3'b010), 5'd0, 1'b0, 32'd0);
    expect_retire(i_type(12'd0, 5'd2, 3'b010, 5'd3, OPC_LOAD), 5'd3, 1'b1, w);
    expect_retire(i_type(12'd1, 5'd2, 3'b000, 5'd4, OPC_LOAD), 5'd4, 1'b1,
                  {{24{w[15]}}, w[15:8]});
    expect_retire(i_type(12'd3, 5'd2, 3'b100, 5'd5, OPC_LOAD), 5'd5, 1'b1, {24'b0, w[31:24]});
    expect_retire(i_type(12'd2, 5'd2, 3'b001, 5'd6, OPC_LOAD), 5'd6, 1'b1,
                  {{16{w[31]}}, w[31:16]});
    expect_retire(i_type(12'd0, 5'd2, 3'b101, 5'd7, OPC_LOAD), 5'd7, 1'b1, {16'b0, w[15:0]});
    build_const(5'd8, v);
    // clear the word, then sb at +5 and sh at +6
    expect_retire(s_type(12'd4, 5'd0, 5'd2, 3'b010), 5'd0, 1'b0, 32'd0);
    expect_retire(s_type(12'd5, 5'd8, 5'd2, 3'b000), 5'd0, 1'b0, 32'd0);
    expect_retire(s_type(12'd6, 5'd8, 5'd2, 3'b001), 5'd0, 1'b0, 32'd0);
    expect_retire(i_type(12'd4, 5'd2, 3'b010, 5'd9, OPC_LOAD), 5'd9, 1'b1,
                  {v[15:0], v[7:0], 8'h00});
    expect_retire(i_type(12'd6, 5'd2, 3'b001, 5'd10, OPC_LOAD), 5'd10, 1'b1,
                  {{16{v[15]}}, v[15:0]});
    expect_retire(i_type(12'd5, 5'd2, 3'b000, 5'd11, OPC_LOAD), 5'd11, 1'b1,
                  {{24{v[7]}}, v[7:0]});
    expect_retire(i_type(12'd5, 5'd2, 3'b100, 5'd12, OPC_LOAD), 5'd12, 1'b1, {24'b0, v[7:0]});
    // byte 4 replaced, byte 5 kept
    expect_retire(s_type(12'd4, 5'd1, 5'd2, 3'b000), 5'd0, 1'b0, 32'd0);
    expect_retire(i_type(12'd4, 5'd2, 3'b101, 5'd13, OPC_LOAD), 5'd13, 1'b1,
                  {16'b0, v[7:0], w[7:0]});
    expect_retire(EBREAK_INSTR, 5'd0, 1'b0, 32'd0);
    run_program("load/store", 1'b1, 1'b0);
  endtask

  // branch over one instruction, filler runs only when not taken
  function automatic void branch_pair(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                      logic taken, logic [4:0] fill_rd);
    expect_retire(b_type(13'd8, rs2, rs1, f3), 5'd0, 1'b0, 32'd0);
    if (taken) begin
      skip_over(i_type(12'd1, 5'd0, F3_ADD_SUB, 5'd20, OPC_OP_IMM));
    end else begin
      expect_retire(i_type(12'd1, 5'd0, F3_ADD_SUB, fill_rd, OPC_OP_IMM), fill_rd, 1'b1,
                    32'd1);
    end
  endfunction

  task automatic branch_conditions();
    new_program();
    // x1 = -5, x2 = 3, signed and unsigned orders differ
    expect_retire(i_type(12'hffb, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM), 5'd1, 1'b1,
                  32'hffff_fffb);
    expect_retire(i_type(12'd3, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM), 5'd2, 1'b1, 32'd3);
    branch_pair(F3_BEQ, 5'd1, 5'd1, 1'b1, 5'd3);
    branch_pair(F3_BEQ, 5'd1, 5'd2, 1'b0, 5'd3);
    branch_pair(F3_BNE, 5'd1, 5'd2, 1'b1, 5'd4);
    branch_pair(F3_BNE, 5'd1, 5'd1, 1'b0, 5'd4);
    branch_pair(F3_BLT, 5'd1, 5'd2, 1'b1, 5'd5);
    branch_pair(F3_BLT, 5'd2, 5'd1, 1'b0, 5'd5);
    branch_pair(F3_BGE, 5'd2, 5'd1, 1'b1, 5'd6);
    branch_pair(F3_BGE, 5'd2, 5'd2, 1'b1, 5'd6);
    branch_pair(F3_BGE, 5'd1, 5'd2, 1'b0, 5'd6);
    branch_pair(F3_BLTU, 5'd2, 5'd1, 1'b1, 5'd7);
    branch_pair(F3_BLTU, 5'd1, 5'd2, 1'b0, 5'd7);
    branch_pair(F3_BGEU, 5'd1, 5'd2, 1'b1, 5'd8);
    branch_pair(F3_BGEU, 5'd2, 5'd1, 1'b0, 5'd8);
    expect_retire(EBREAK_INSTR, 5'd0, 1'b0, 32'd0);
    run_program("branch", 1'b1, 1'b0);
  endtask

  task automatic jumps_and_auipc();
    word_t filler;
    filler = i_type(12'd1, 5'd0, F3_ADD_SUB, 5'd20, OPC_OP_IMM);
    new_program();
    // jal from 0 to 12
    expect_retire(j_type(21'd12, 5'd1), 5'd1, 1'b1, next_pc() + 32'd4);
    skip_over(filler);
    skip_over(filler);
    expect_retire(u_type(20'h12345, 5'd3, OPC_AUIPC), 5'd3, 1'b1, next_pc() + 32'h1234_5000);
    // odd base, jalr target 33 becomes 32
    expect_retire(i_type(12'd33, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM), 5'd2, 1'b1, 32'd33);
    expect_retire(i_type(12'd0, 5'd2, 3'b000, 5'd4, OPC_JALR), 5'd4, 1'b1, next_pc() + 32'd4);
    skip_over(filler);
    skip_over(filler);
    // negative auipc immediate
    expect_retire(u_type(20'hfffff, 5'd8, OPC_AUIPC), 5'd8, 1'b1, next_pc() + 32'hffff_f000);
    // 33 + 12 = 45, lands on 44
    expect_retire(i_type(12'd12, 5'd2, 3'b000, 5'd9, OPC_JALR), 5'd9, 1'b1, next_pc() + 32'd4);
    skip_over(filler);
    expect_retire(EBREAK_INSTR, 5'd0, 1'b0, 32'd0);
    run_program("jump", 1'b1, 1'b0);
  endtask

  task automatic halt_on_ebreak();
    new_program();
    expect_retire(i_type(12'd7, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM), 5'd1, 1'b1, 32'd7);
    expect_retire(EBREAK_INSTR, 5'd0, 1'b0, 32'd0);
    skip_over(i_type(12'd9, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM));
    run_program("halt", 1'b1, 1'b0);
    stays_halted(4, "after ebreak");
    // run low then high again must not restart anything
    run = 1'b0;
    stays_halted(3, "run low");
    run = 1'b1;
    stays_halted(5, "run high again");
  endtask

  task automatic illegal_ecall();
    logic [11:0] r;
    r = 12'($random(seed));
    new_program();
    expect_retire(i_type(r, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM), 5'd1, 1'b1, sext12(r));
    expect_retire(i_type(12'd1, 5'd1, F3_ADD_SUB, 5'd2, OPC_OP_IMM), 5'd2, 1'b1,
                  sext12(r) + 32'd1);
    // ecall, then an instruction that must never run
    skip_over(32'h0000_0073);
    skip_over(i_type(12'd5, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM));
    run_program("illegal", 1'b0, 1'b1);
    // register file keeps its contents across reset
    new_program();
    expect_retire(r_type(F7_BASE, 5'd0, 5'd1, F3_ADD_SUB, 5'd10), 5'd10, 1'b1, sext12(r));
    expect_retire(r_type(F7_BASE, 5'd0, 5'd2, F3_ADD_SUB, 5'd11), 5'd11, 1'b1,
                  sext12(r) + 32'd1);
    expect_retire(EBREAK_INSTR, 5'd0, 1'b0, 32'd0);
    run_program("illegal readback", 1'b1, 1'b0);
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    seed       = 32'hf90d8d05;
    arithmetic_ops();
    load_store_widths();
    branch_conditions();
    jumps_and_auipc();
    halt_on_ebreak();
    illegal_ecall();
    $display("errors: retire %0d, flag %0d, sequence %0d", retire_errors, flag_errors,
             seq_errors);
    if ((retire_errors + flag_errors + seq_errors) == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb.f
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/fetch_unit.sv
hw/stage_reg.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/data_mem.sv
hw/rv_core.sv
sim/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# build the rv_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f tb.f \
  --Mdir obj_dir -o tb_rv_core
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# pass only when the testbench printed its pass line
if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
